//--- build.f
design/cluster_cfg_pkg.sv
design/ctrl_bus_pkg.sv
design/ctrl_registers.sv
design/wake_pending.sv
design/settle_timer.sv
design/wake_sequencer.sv
design/cluster_ctrl_top.sv
testbench/cluster_ctrl_assert.sv
testbench/cluster_ctrl_tb.sv

//--- Makefile
TOP := cluster_ctrl_tb
LOG := sim.log

all: run

obj_dir/V$(TOP): build.f $(wildcard design/*.sv testbench/*.sv)
	verilator --binary --timing --assert -f build.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG) || ! grep -q "Regression passed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean

//--- testbench/cluster_ctrl_tb.sv
//##########################################################
// cluster control testbench
// drives the wishbone port, logs wake pulses and checks
// register reads and pulse order against the register map
//##########################################################

module cluster_ctrl_tb
  import cluster_cfg_pkg::*;
  import ctrl_bus_pkg::*;
();

  localparam int AckTimeout   = 20;
  localparam int IdleTimeout  = 40;
  localparam int PulseTimeout = 400;

  logic        clk_i;
  logic        reset_i;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  core_mask_t  wake;

  // pulse log with each mask and the cycle it was seen in
  core_mask_t  pulse_mask_q[$];
  int unsigned pulse_cyc_q[$];
  int unsigned cycle_count = 0;

  string       test_name;
  int unsigned error_count  = 0;
  int unsigned check_count  = 0;
  int unsigned tests_run    = 0;
  int unsigned tests_failed = 0;
  int unsigned errors_at_start;

  cluster_ctrl_top UUT (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp),
    .wake_o   (wake)
  );

  bind cluster_ctrl_top cluster_ctrl_assert u_assert (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .wb_req_i  (wb_req_i),
    .wb_rsp_i  (wb_rsp_o),
    .wake_i    (wake_o),
    .pending_i (pending),
    .busy_i    (busy),
    .settle_i  (settle)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
  end

  // pulses sampled mid-cycle where wake is settled
  always @(negedge clk_i) begin
    if (!reset_i && wake != '0) begin
      pulse_mask_q.push_back(wake);
      pulse_cyc_q.push_back(cycle_count);
    end
  end

  function automatic int unsigned total_errors();
    return error_count + UUT.u_assert.fail_total;
  endfunction

  // one classic cycle with the request held until ack and stb dropped after it
  task automatic bus_access(input logic we, input logic [AddrWidth-1:0] adr,
                            input logic [DataWidth-1:0] wdat,
                            output logic [DataWidth-1:0] rdat);
    wb_req_t req;
    int      waited;
    logic    got;
    req     = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = adr;
    req.dat = wdat;
    rdat    = '0;
    got     = 1'b0;
    waited  = 0;
    @(posedge clk_i);
    wb_req <= req;
    while (!got && waited < AckTimeout) begin
      @(negedge clk_i);
      if (wb_rsp.ack) begin
        got  = 1'b1;
        rdat = wb_rsp.dat;
      end else begin
        waited++;
      end
    end
    @(posedge clk_i);
    wb_req <= '0;
    if (!got) begin
      $display("Error in %s: no ack for the access to offset %h", test_name, adr);
      error_count++;
    end
  endtask

  task automatic reg_write(input logic [AddrWidth-1:0] adr, input logic [DataWidth-1:0] dat);
    logic [DataWidth-1:0] unused;
    bus_access(1'b1, adr, dat, unused);
  endtask

  task automatic reg_read(input logic [AddrWidth-1:0] adr, output logic [DataWidth-1:0] dat);
    bus_access(1'b0, adr, '0, dat);
  endtask

  task automatic check_value(input string what, input logic [DataWidth-1:0] expected,
                             input logic [DataWidth-1:0] actual);
    check_count++;
    if (actual !== expected) begin
      $display("Mismatch in %s, %s: expected %h, actual %h", test_name, what, expected, actual);
      error_count++;
    end
  endtask

  // pulse number idx has to wake core and nothing else
  task automatic check_pulse(input int idx, input int unsigned core);
    core_mask_t exp_mask;
    exp_mask = core_mask_t'(1) << core;
    check_value($sformatf("pulse %0d mask", idx), DataWidth'(exp_mask),
                DataWidth'(pulse_mask_q[idx]));
  endtask

  task automatic wait_for_pulses(input int n);
    int waited;
    waited = 0;
    while (pulse_mask_q.size() < n && waited < PulseTimeout) begin
      @(posedge clk_i);
      waited++;
    end
    if (pulse_mask_q.size() < n) begin
      $display("Error in %s: only %0d of %0d wake pulses seen", test_name,
               pulse_mask_q.size(), n);
      error_count++;
    end
  endtask

  // poll status until the busy flag drops
  task automatic wait_until_idle(output logic [DataWidth-1:0] status);
    int polls;
    polls = 0;
    reg_read(RegStatus, status);
    while (status[DataWidth-1] && polls < IdleTimeout) begin
      reg_read(RegStatus, status);
      polls++;
    end
    if (status[DataWidth-1]) begin
      $display("Error in %s: sequencer still busy after %0d status reads", test_name, polls);
      error_count++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = total_errors();
    pulse_mask_q.delete();
    pulse_cyc_q.delete();
  endtask

  task automatic end_test();
    tests_run++;
    if (total_errors() != errors_at_start) begin
      tests_failed++;
      $display("test %s: failed", test_name);
    end else begin
      $display("test %s: ok", test_name);
    end
  endtask

  initial begin
    logic [DataWidth-1:0] rd;
    logic [DataWidth-1:0] settle;
    int unsigned          core;
    int unsigned          extra;
    reset_i <= 1'b1;
    wb_req  <= '0;
    void'($urandom(32'h22df_571f));
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;

    // description registers read before and after writes to them
    begin_test("readback");
    for (int pass = 0; pass < 2; pass++) begin
      reg_read(RegTcdmStart, rd);
      check_value("tcdm start", TcdmBaseAddr, rd);
      reg_read(RegTcdmEnd, rd);
      check_value("tcdm end", TcdmBaseAddr + TcdmSize, rd);
      reg_read(RegNumCores, rd);
      check_value("core count", DataWidth'(NumCores), rd);
      reg_read(RegWakeUp, rd);
      check_value("wake register", '0, rd);
      reg_read(8'h18, rd);
      check_value("unmapped 0x18", '0, rd);
      reg_read(8'hFC, rd);
      check_value("unmapped 0xfc", '0, rd);
      if (pass == 0) begin
        reg_write(RegTcdmStart, $urandom());
        reg_write(RegTcdmEnd, $urandom());
        reg_write(RegNumCores, $urandom());
        reg_write(8'h18, $urandom());
        reg_write(8'hFC, $urandom());
      end
    end
    end_test();

    begin_test("settle register");
    reg_read(RegSettle, rd);
    check_value("settle after reset", SettleRstVal, rd);
    settle = $urandom();
    reg_write(RegSettle, settle);
    reg_read(RegSettle, rd);
    check_value("settle readback", settle, rd);
    end_test();

    begin_test("single wake");
    reg_write(RegSettle, $urandom_range(6, 1));
    core = $urandom_range(NumCores - 1, 0);
    reg_write(RegWakeUp, core);
    wait_for_pulses(1);
    wait_until_idle(rd);
    check_value("status", '0, rd);
    check_value("pulse count", 1, pulse_mask_q.size());
    check_pulse(0, core);
    end_test();

    // ascending order with settle plus 2 cycles between pulses
    begin_test("broadcast");
    settle = $urandom_range(6, 1);
    reg_write(RegSettle, settle);
    reg_write(RegWakeUp, WakeAll);
    wait_for_pulses(NumCores);
    wait_until_idle(rd);
    check_value("pulse count", NumCores, pulse_mask_q.size());
    for (int i = 0; i < pulse_mask_q.size(); i++) begin
      check_pulse(i, i);
      if (i > 0) begin
        check_value($sformatf("gap before pulse %0d", i), settle + 2,
                    pulse_cyc_q[i] - pulse_cyc_q[i-1]);
      end
    end
    end_test();

    begin_test("invalid value");
    reg_write(RegWakeUp, NumCores);
    repeat (50) @(posedge clk_i);
    reg_write(RegWakeUp, $urandom_range(32'hFFFF_FFFE, NumCores + 1));
    repeat (50) @(posedge clk_i);
    check_value("pulse count", 0, pulse_mask_q.size());
    end_test();

    // re-request lands in the gap after the last core
    // and is pulsed once more after all the others
    begin_test("merge while busy");
    reg_write(RegSettle, $urandom_range(8, 5));
    reg_write(RegWakeUp, WakeAll);
    wait_for_pulses(NumCores);
    extra = $urandom_range(NumCores - 1, 0);
    reg_write(RegWakeUp, extra);
    reg_read(RegStatus, rd);
    check_value("status busy", 1, DataWidth'(rd[DataWidth-1]));
    check_value("status bitmap non-empty", 1, DataWidth'(rd[NumCores-1:0] != '0));
    wait_for_pulses(NumCores + 1);
    wait_until_idle(rd);
    check_value("pulse count", NumCores + 1, pulse_mask_q.size());
    for (int i = 0; i < pulse_mask_q.size(); i++) begin
      check_pulse(i, (i < NumCores) ? i : extra);
    end
    end_test();

    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, total_errors());
    if (total_errors() == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // whole-run limit
  initial begin
    repeat (20000) @(posedge clk_i);
    $display("Error: simulation did not finish within 20000 cycles");
    $display("Regression failed");
    $finish;
  end

endmodule : cluster_ctrl_tb

//--- testbench/cluster_ctrl_assert.sv
//##########################################################
// cluster control assertions
// wake pulse shape, pulse spacing and wishbone ack rules
//##########################################################

module cluster_ctrl_assert
  import cluster_cfg_pkg::*;
  import ctrl_bus_pkg::*;
(
  input logic                 clk_i,
  input logic                 reset_i,
  input wb_req_t              wb_req_i,
  input wb_rsp_t              wb_rsp_i,
  input core_mask_t           wake_i,
  input core_mask_t           pending_i,
  input logic                 busy_i,
  input logic [DataWidth-1:0] settle_i
);

  // failure counts per property, summed for the testbench
  int unsigned onehot_fails = 0;
  int unsigned ack_fails    = 0;
  int unsigned gap_fails    = 0;
  int unsigned pulse_fails  = 0;
  int unsigned fail_total;

  // cycles since the last pulse and the least gap it allows
  logic                 seen_q;
  logic [DataWidth-1:0] gap_q;
  logic [DataWidth-1:0] gap_min_q;

  assign fail_total = onehot_fails + ack_fails + gap_fails + pulse_fails;

  // a zero settle value runs the timer for one cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      seen_q    <= 1'b0;
      gap_q     <= '0;
      gap_min_q <= '0;
    end else if (wake_i != '0) begin
      seen_q    <= 1'b1;
      gap_q     <= DataWidth'(1);
      gap_min_q <= ((settle_i == '0) ? DataWidth'(1) : settle_i) + DataWidth'(2);
    end else if (gap_q != '1) begin
      gap_q <= gap_q + DataWidth'(1);
    end
  end

  // at most one core woken per cycle
  assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(wake_i))
    else begin
      $error("wake pulse is not one-hot: %b", wake_i);
      onehot_fails++;
    end

  // single-cycle ack, only after an open access
  assert property (@(posedge clk_i) disable iff (reset_i)
    wb_rsp_i.ack |-> ($past(wb_req_i.cyc && wb_req_i.stb) && !$past(wb_rsp_i.ack)))
    else begin
      $error("ack without an open access or longer than one cycle");
      ack_fails++;
    end

  // pulses at least settle plus 2 cycles apart
  assert property (@(posedge clk_i) disable iff (reset_i)
    (wake_i != '0 && seen_q) |-> (gap_q >= gap_min_q))
    else begin
      $error("wake pulses only %0d cycles apart, need %0d", gap_q, gap_min_q);
      gap_fails++;
    end

  // a pulse needs an idle sequencer and a pending bit one cycle earlier
  assert property (@(posedge clk_i) disable iff (reset_i)
    (wake_i != '0) |-> (!$past(busy_i) && (($past(pending_i) & wake_i) == wake_i)))
    else begin
      $error("wake pulse %b without a pending request", wake_i);
      pulse_fails++;
    end

endmodule : cluster_ctrl_assert

//--- design/cluster_ctrl_top.sv
//##########################################################
// cluster control top
// register file, pending bitmap, settle timer and wake
// sequencer behind one wishbone slave port
//##########################################################

module cluster_ctrl_top
  import cluster_cfg_pkg::*;
  import ctrl_bus_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  wb_req_t    wb_req_i,
  output wb_rsp_t    wb_rsp_o,
  output core_mask_t wake_o
);

  // register file to bitmap and back
  core_mask_t             wake_req;
  core_mask_t             pending;
  logic                   busy;
  logic [DataWidth-1:0]   settle;

  // bitmap to sequencer
  logic                   pick_valid;
  logic [CoreIdWidth-1:0] pick_id;
  core_mask_t             grant;

  // sequencer to timer
  logic                   timer_start;
  logic                   timer_done;

  ctrl_registers u_regs (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .wb_req_i   (wb_req_i),
    .wb_rsp_o   (wb_rsp_o),
    .pending_i  (pending),
    .busy_i     (busy),
    .settle_o   (settle),
    .wake_req_o (wake_req)
  );

  wake_pending u_pending (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .set_i        (wake_req),
    .clear_i      (grant),
    .pending_o    (pending),
    .pick_valid_o (pick_valid),
    .pick_id_o    (pick_id)
  );

  settle_timer u_timer (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .start_i  (timer_start),
    .cycles_i (settle),
    .done_o   (timer_done)
  );

  wake_sequencer u_seq (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .pick_valid_i  (pick_valid),
    .pick_id_i     (pick_id),
    .timer_done_i  (timer_done),
    .timer_start_o (timer_start),
    .grant_o       (grant),
    .wake_o        (wake_o),
    .busy_o        (busy)
  );

endmodule : cluster_ctrl_top

//--- design/wake_sequencer.sv
//##########################################################
// wake sequencer
// FSM that wakes the pending cores one at a time, with a
// settle gap between two pulses
//##########################################################

module wake_sequencer
  import cluster_cfg_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   pick_valid_i,
  input  logic [CoreIdWidth-1:0] pick_id_i,
  input  logic                   timer_done_i,
  output logic                   timer_start_o,
  output core_mask_t             grant_o,
  output core_mask_t             wake_o,
  output logic                   busy_o
);

  seq_state_e             state_q;
  seq_state_e             state_d;
  logic [CoreIdWidth-1:0] core_q;
  core_mask_t             wake;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= SEQ_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // chosen core, only looked at in SEQ_PULSE
  always_ff @(posedge clk_i) begin
    if (state_q == SEQ_IDLE && pick_valid_i) begin
      core_q <= pick_id_i;
    end
  end

  // next state and pulse outputs
  always_comb begin
    state_d       = state_q;
    wake          = '0;
    timer_start_o = 1'b0;
    case (state_q)
      SEQ_IDLE: begin
        if (pick_valid_i) begin
          state_d = SEQ_PULSE;
        end
      end
      // one cycle, one-hot on the latched core
      SEQ_PULSE: begin
        wake          = core_mask_t'(1) << core_q;
        timer_start_o = 1'b1;
        state_d       = SEQ_SETTLE;
      end
      // hold off the next pick until the gap is over
      SEQ_SETTLE: begin
        if (timer_done_i) begin
          state_d = SEQ_IDLE;
        end
      end
      default: state_d = SEQ_IDLE;
    endcase
  end

  // pulse doubles as the clear for the pending bit
  assign wake_o  = wake;
  assign grant_o = wake;
  assign busy_o  = (state_q != SEQ_IDLE);

endmodule : wake_sequencer

//--- design/settle_timer.sv
//##########################################################
// settle timer
// loadable down-counter that flags the end of the gap
// between two wake pulses
//##########################################################

module settle_timer
  import cluster_cfg_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 start_i,
  input  logic [DataWidth-1:0] cycles_i,
  output logic                 done_o
);

  logic [DataWidth-1:0] count_q;

  // start reloads even if a count is still running
  // a zero length gap is stretched to one cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (start_i) begin
      count_q <= (cycles_i == '0) ? DataWidth'(1) : cycles_i;
    end else if (count_q != '0) begin
      count_q <= count_q - DataWidth'(1);
    end
  end

  // done in the last cycle of the gap, N cycles after start,
  // the counter reaches zero on the following edge
  assign done_o = (count_q == DataWidth'(1));

endmodule : settle_timer

//--- design/wake_pending.sv
//##########################################################
// pending wake bitmap
// collects wake requests per core and names the lowest
// core that still waits for its pulse
//##########################################################

module wake_pending
  import cluster_cfg_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  core_mask_t             set_i,
  input  core_mask_t             clear_i,
  output core_mask_t             pending_o,
  output logic                   pick_valid_o,
  output logic [CoreIdWidth-1:0] pick_id_o
);

  core_mask_t             pending_q;
  core_mask_t             pending_d;
  logic [CoreIdWidth-1:0] pick_id;

  // clear first, then set, so a new request wins
  assign pending_d = (pending_q & ~clear_i) | set_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
    end
  end

  // priority encoder
  // scan from the top so the lowest set bit is the last one written
  always_comb begin
    pick_id = '0;
    for (int i = NumCores - 1; i >= 0; i--) begin
      if (pending_q[i]) begin
        pick_id = CoreIdWidth'(i);
      end
    end
  end

  // any core waiting
  assign pick_valid_o = |pending_q;
  assign pick_id_o    = pick_id;
  assign pending_o    = pending_q;

endmodule : wake_pending

//--- design/ctrl_registers.sv
//##########################################################
// cluster control register file
// wishbone classic slave with the description registers,
// settle delay, status and the wake register decoder
//##########################################################

module ctrl_registers
  import cluster_cfg_pkg::*;
  import ctrl_bus_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  wb_req_t              wb_req_i,
  output wb_rsp_t              wb_rsp_o,
  input  core_mask_t           pending_i,
  input  logic                 busy_i,
  output logic [DataWidth-1:0] settle_o,
  output core_mask_t           wake_req_o
);

  // bus handshake
  logic                   access_open;
  logic                   accept;
  logic                   ack_q;
  logic [AddrWidth-3:0]   word_off;
  logic [DataWidth-1:0]   rdata_d;
  logic [DataWidth-1:0]   rdata_q;

  // register storage
  logic [DataWidth-1:0]   settle_q;

  // wake path, value and strobe first, decoded mask one cycle later
  logic                   wake_stb_q;
  logic [DataWidth-1:0]   wake_val_q;
  core_mask_t             wake_dec;
  core_mask_t             wake_req_q;

  // access is open while cyc and stb are both high
  assign access_open = wb_req_i.cyc & wb_req_i.stb;

  // take the access once, ack blocks a second accept
  assign accept = access_open & ~ack_q;

  // byte address down to a word index
  assign word_off = wb_req_i.adr[AddrWidth-1:2];

  // read mux
  always_comb begin
    rdata_d = '0;
    case (word_off)
      RegTcdmStart[AddrWidth-1:2]: rdata_d = TcdmBaseAddr;
      RegTcdmEnd[AddrWidth-1:2]:   rdata_d = TcdmBaseAddr + TcdmSize;
      RegNumCores[AddrWidth-1:2]:  rdata_d = DataWidth'(NumCores);
      // wake register is write only
      RegWakeUp[AddrWidth-1:2]:    rdata_d = '0;
      RegSettle[AddrWidth-1:2]:    rdata_d = settle_q;
      // bitmap in the low byte, busy in the top bit
      RegStatus[AddrWidth-1:2]: begin
        rdata_d = {busy_i, {(DataWidth-NumCores-1){1'b0}}, pending_i};
      end
      // unmapped reads return zero
      default:                     rdata_d = '0;
    endcase
  end

  // single-cycle ack, one clock after the access opens
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= accept;
    end
  end

  // read data captured together with ack
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= wb_req_i.we ? '0 : rdata_d;
    end
  end

  // settle register, written on the ack edge
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      settle_q <= SettleRstVal;
    end else if (accept && wb_req_i.we && word_off == RegSettle[AddrWidth-1:2]) begin
      settle_q <= wb_req_i.dat;
    end
  end

  // wake write strobe, high during the ack cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wake_stb_q <= 1'b0;
    end else begin
      wake_stb_q <= accept & wb_req_i.we & (word_off == RegWakeUp[AddrWidth-1:2]);
    end
  end

  // written wake value
  always_ff @(posedge clk_i) begin
    if (accept && wb_req_i.we && word_off == RegWakeUp[AddrWidth-1:2]) begin
      wake_val_q <= wb_req_i.dat;
    end
  end

  // decode: index below the core count wakes that core,
  // all ones wakes every core, anything else is dropped
  always_comb begin
    wake_dec = '0;
    if (wake_val_q < DataWidth'(NumCores)) begin
      wake_dec = core_mask_t'(1) << wake_val_q[CoreIdWidth-1:0];
    end else if (wake_val_q == WakeAll) begin
      wake_dec = '1;
    end
  end

  // request mask, valid for one cycle after the ack cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wake_req_q <= '0;
    end else begin
      wake_req_q <= wake_stb_q ? wake_dec : '0;
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdata_q;
  assign settle_o     = settle_q;
  assign wake_req_o   = wake_req_q;

endmodule : ctrl_registers

//--- design/ctrl_bus_pkg.sv
//##########################################################
// control bus package
// wishbone classic request and response structs, the
// register map of the cluster control block and the
// register reset values
//##########################################################

package ctrl_bus_pkg;

  import cluster_cfg_pkg::*;

  // byte address width of the control port
  localparam int unsigned AddrWidth = 8;

  // host to slave, held stable until ack is seen
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [AddrWidth-1:0] adr;
    logic [DataWidth-1:0] dat;
  } wb_req_t;

  // slave to host, dat only meaningful while ack is high
  typedef struct packed {
    logic                 ack;
    logic [DataWidth-1:0] dat;
  } wb_rsp_t;

  // register byte offsets, one 32-bit word each
  localparam logic [AddrWidth-1:0] RegTcdmStart = 8'h00;
  localparam logic [AddrWidth-1:0] RegTcdmEnd   = 8'h04;
  localparam logic [AddrWidth-1:0] RegNumCores  = 8'h08;
  localparam logic [AddrWidth-1:0] RegWakeUp    = 8'h0C;
  localparam logic [AddrWidth-1:0] RegSettle    = 8'h10;
  localparam logic [AddrWidth-1:0] RegStatus    = 8'h14;

  // settle gap after reset, in cycles
  localparam logic [DataWidth-1:0] SettleRstVal = 32'd4;

  // wake value that addresses every core at once
  localparam logic [DataWidth-1:0] WakeAll = '1;

endpackage : ctrl_bus_pkg

//--- design/cluster_cfg_pkg.sv
//##########################################################
// cluster configuration package
// core count, bus word width, scratchpad placement and the
// state encoding of the wake sequencer
//##########################################################

package cluster_cfg_pkg;

  // number of cores in the cluster, also the width of every core mask
  localparam int unsigned NumCores = 8;

  // bits for a core index
  localparam int unsigned CoreIdWidth = 3;

  // bus word width
  localparam int unsigned DataWidth = 32;

  // shared scratchpad (tcdm) start address in bytes
  localparam logic [DataWidth-1:0] TcdmBaseAddr = 32'h0010_0000;

  // scratchpad size in bytes, 128 KiB
  localparam logic [DataWidth-1:0] TcdmSize = 32'h0002_0000;

  // one bit per core, bit i is core i
  typedef logic [NumCores-1:0] core_mask_t;

  // wake sequencer states
  // idle waits for a pending core
  // pulse drives the wake line for one cycle
  // settle waits for the supply current to ramp
  typedef enum logic [1:0] {
    SEQ_IDLE   = 2'd0,
    SEQ_PULSE  = 2'd1,
    SEQ_SETTLE = 2'd2
  } seq_state_e;

endpackage : cluster_cfg_pkg
